// ==== cmos_if_pkg.sv ====
package cmos_if_pkg;

  // ************************************************************
  // bus and word widths
  // ************************************************************

  // one bus half carries a single I or Q value
  localparam int HALF_W = 12;

  // one I/Q pair, as carried by both halves of one clock
  localparam int PAIR_W = 2 * HALF_W;

  // two I/Q pairs, rf1 in the low half and rf2 in the high half
  localparam int WORD_W = 4 * HALF_W;

  typedef logic [HALF_W-1:0] half_t;

  // rf1 I, rf1 Q, rf2 I, rf2 Q from the low bits up
  typedef logic [WORD_W-1:0] iq_word_t;

  // ************************************************************
  // mode and state encodings
  // ************************************************************

  // mode_r1 is 1 so that a plain r1_mode bit casts straight across
  typedef enum logic {
    mode_r2 = 1'b0,
    mode_r1 = 1'b1
  } bus_mode_t;

  // four-phase intake on the transmit side
  typedef enum logic [1:0] {
    hs_idle = 2'd0,
    hs_ack  = 2'd1,
    hs_send = 2'd2
  } hs_state_t;

endpackage

// ==== cmos_half_if.sv ====
`timescale 1ns/1ps

interface cmos_half_if;

  import cmos_if_pkg::*;

  // halves and frame pair of the current clock
  half_t data_p;
  half_t data_n;
  logic  frame_p;
  logic  frame_n;

  // held from the clock before, for the shifted cases
  half_t prev_data_n;
  logic  prev_frame_p;
  logic  prev_frame_n;

  modport capture (
    output data_p, data_n, frame_p, frame_n,
    output prev_data_n, prev_frame_p, prev_frame_n
  );

  modport deframe (
    input data_p, data_n, frame_p, frame_n,
    input prev_data_n, prev_frame_p, prev_frame_n
  );

endinterface

// ==== rx_capture.sv ====
`timescale 1ns/1ps

module rx_capture (
  input  logic                l_clk,
  input  logic                rst,
  input  logic                rx_frame_p,
  input  logic                rx_frame_n,
  input  cmos_if_pkg::half_t  rx_data_p,
  input  cmos_if_pkg::half_t  rx_data_n,
  cmos_half_if.capture        bus
);

  // frame bits, current and one clock back
  always_ff @(posedge l_clk or posedge rst) begin
    if (rst) begin
      bus.frame_p      <= 1'b0;
      bus.frame_n      <= 1'b0;
      bus.prev_frame_p <= 1'b0;
      bus.prev_frame_n <= 1'b0;
    end else begin
      bus.frame_p      <= rx_frame_p;
      bus.frame_n      <= rx_frame_n;
      bus.prev_frame_p <= bus.frame_p;
      bus.prev_frame_n <= bus.frame_n;
    end
  end

  // sample halves; only the n half is kept a second clock
  always_ff @(posedge l_clk) begin
    bus.data_p      <= rx_data_p;
    bus.data_n      <= rx_data_n;
    bus.prev_data_n <= bus.data_n;
  end

endmodule

// ==== rx_deframe.sv ====
`timescale 1ns/1ps

module rx_deframe (
  input  logic                    l_clk,
  input  logic                    rst,
  input  cmos_if_pkg::bus_mode_t  r1_mode,
  cmos_half_if.deframe            bus,
  output logic                    adc_valid,
  output logic                    adc_status,
  output cmos_if_pkg::iq_word_t   adc_data
);

  import cmos_if_pkg::*;

  logic [1:0]        pair;
  logic [3:0]        window;
  logic [PAIR_W-1:0] aligned_pair;
  logic [PAIR_W-1:0] shifted_pair;

  logic              r1_valid;
  logic              r1_status;
  logic [PAIR_W-1:0] r1_data;
  logic              r2_valid;
  logic              r2_status;
  iq_word_t          r2_data;

  // pair is (frame_p, frame_n); window puts the previous pair on top
  assign pair   = {bus.frame_p, bus.frame_n};
  assign window = {bus.prev_frame_p, bus.prev_frame_n, pair};

  assign aligned_pair = {bus.data_n, bus.data_p};
  assign shifted_pair = {bus.data_p, bus.prev_data_n};

  // ************************************************************
  // decode stage, both rule sets side by side
  // ************************************************************

  always_ff @(posedge l_clk or posedge rst) begin
    if (rst) begin
      r1_valid  <= 1'b0;
      r1_status <= 1'b0;
      r2_valid  <= 1'b0;
      r2_status <= 1'b0;
    end else begin
      // r1 frame must toggle within the clock
      r1_valid  <= ^pair;
      r1_status <= ^pair;
      // r2 word completes on 1100 aligned or 0110 shifted
      r2_valid  <= (window == 4'b1100) || (window == 4'b0110);
      r2_status <= (window == 4'b1100) || (window == 4'b0011) ||
                   (window == 4'b1001) || (window == 4'b0110);
    end
  end

  always_ff @(posedge l_clk) begin
    case (pair)
      2'b10:   r1_data <= aligned_pair;
      2'b01:   r1_data <= shifted_pair;
      default: r1_data <= '0;
    endcase
    // rf1 half of the r2 word
    case (pair)
      2'b11: r2_data[PAIR_W-1:0] <= aligned_pair;
      2'b01: r2_data[PAIR_W-1:0] <= shifted_pair;
      default: r2_data[PAIR_W-1:0] <= r2_data[PAIR_W-1:0];
    endcase
    // rf2 half, taken on the clock that completes the word
    case (pair)
      2'b00: r2_data[WORD_W-1:PAIR_W] <= aligned_pair;
      2'b10: r2_data[WORD_W-1:PAIR_W] <= shifted_pair;
      default: r2_data[WORD_W-1:PAIR_W] <= r2_data[WORD_W-1:PAIR_W];
    endcase
  end

  // ************************************************************
  // output stage, mode select
  // ************************************************************

  always_ff @(posedge l_clk or posedge rst) begin
    if (rst) begin
      adc_valid  <= 1'b0;
      adc_status <= 1'b0;
    end else if (r1_mode == mode_r1) begin
      adc_valid  <= r1_valid;
      adc_status <= r1_status;
    end else begin
      adc_valid  <= r2_valid;
      adc_status <= r2_status;
    end
  end

  always_ff @(posedge l_clk) begin
    if (r1_mode == mode_r1) begin
      adc_data <= {{PAIR_W{1'b0}}, r1_data};
    end else begin
      adc_data <= r2_data;
    end
  end

endmodule

// ==== tx_framer.sv ====
`timescale 1ns/1ps

module tx_framer (
  input  logic                    l_clk,
  input  logic                    rst,
  input  cmos_if_pkg::bus_mode_t  r1_mode,
  input  logic                    dac_req,
  input  cmos_if_pkg::iq_word_t   dac_data,
  output logic                    dac_ack,
  output logic                    tx_frame_p,
  output logic                    tx_frame_n,
  output cmos_if_pkg::half_t      tx_data_p,
  output cmos_if_pkg::half_t      tx_data_n
);

  import cmos_if_pkg::*;

  hs_state_t state;
  logic      pair_idx;
  logic      last_pair;
  logic      accept;
  iq_word_t  word;
  bus_mode_t word_mode;

  // new word only from idle, which is reached once ack is low again
  assign accept = (state == hs_idle) && dac_req;

  // r1 words take one bus clock, r2 words take two
  assign last_pair = (word_mode == mode_r1) || pair_idx;

  // ************************************************************
  // handshake and frame sequencing
  // ************************************************************

  always_ff @(posedge l_clk or posedge rst) begin
    if (rst) begin
      state      <= hs_idle;
      dac_ack    <= 1'b0;
      pair_idx   <= 1'b0;
      tx_frame_p <= 1'b0;
      tx_frame_n <= 1'b0;
    end else begin
      // ack falls on the clock after req is seen low
      if (dac_ack && !dac_req) begin
        dac_ack <= 1'b0;
      end
      tx_frame_p <= 1'b0;
      tx_frame_n <= 1'b0;
      case (state)
        hs_idle: begin
          if (accept) begin
            dac_ack  <= 1'b1;
            pair_idx <= 1'b0;
            state    <= hs_send;
          end
        end
        hs_send: begin
          // (1,0) for r1, then (1,1) and (0,0) for r2
          tx_frame_p <= ~pair_idx;
          tx_frame_n <= (word_mode == mode_r2) && !pair_idx;
          pair_idx   <= 1'b1;
          if (last_pair) begin
            state <= hs_ack;
          end
        end
        hs_ack: begin
          // wait for the source to finish the four-phase cycle
          if (!dac_ack) begin
            state <= hs_idle;
          end
        end
        default: state <= hs_idle;
      endcase
    end
  end

  // word latch and bus halves
  always_ff @(posedge l_clk) begin
    if (accept) begin
      word      <= dac_data;
      word_mode <= r1_mode;
    end
    if (state != hs_send) begin
      tx_data_p <= '0;
      tx_data_n <= '0;
    end else if (pair_idx) begin
      tx_data_p <= word[3*HALF_W-1:2*HALF_W];
      tx_data_n <= word[4*HALF_W-1:3*HALF_W];
    end else begin
      tx_data_p <= word[HALF_W-1:0];
      tx_data_n <= word[2*HALF_W-1:HALF_W];
    end
  end

endmodule

// ==== ensm_ctrl.sv ====
`timescale 1ns/1ps

module ensm_ctrl #(
  parameter int SYNC_STAGES = 2
) (
  input  logic l_clk,
  input  logic rst,
  input  logic up_enable,
  input  logic up_txnrx,
  input  logic tdd_mode,
  input  logic tdd_enable,
  input  logic tdd_txnrx,
  output logic enable,
  output logic txnrx
);

  logic [SYNC_STAGES-1:0] enable_sync;
  logic [SYNC_STAGES-1:0] txnrx_sync;

  // host requests come from another domain, bring them in through a chain
  always_ff @(posedge l_clk or posedge rst) begin
    if (rst) begin
      enable_sync <= '0;
      txnrx_sync  <= '0;
    end else begin
      enable_sync[0] <= up_enable;
      txnrx_sync[0]  <= up_txnrx;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        enable_sync[i] <= enable_sync[i-1];
        txnrx_sync[i]  <= txnrx_sync[i-1];
      end
    end
  end

  // tdd inputs are already local and bypass the chain
  always_ff @(posedge l_clk or posedge rst) begin
    if (rst) begin
      enable <= 1'b0;
      txnrx  <= 1'b0;
    end else if (tdd_mode) begin
      enable <= tdd_enable;
      txnrx  <= tdd_txnrx;
    end else begin
      enable <= enable_sync[SYNC_STAGES-1];
      txnrx  <= txnrx_sync[SYNC_STAGES-1];
    end
  end

endmodule

// ==== cmos_if_top.sv ====
`timescale 1ns/1ps

module cmos_if_top #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                   l_clk,
  input  logic                   rst,
  // receive pins, already split into halves
  input  logic                   rx_r1_mode,
  input  logic                   rx_frame_p,
  input  logic                   rx_frame_n,
  input  cmos_if_pkg::half_t     rx_data_p,
  input  cmos_if_pkg::half_t     rx_data_n,
  output logic                   adc_valid,
  output logic                   adc_status,
  output cmos_if_pkg::iq_word_t  adc_data,
  // transmit side
  input  logic                   tx_r1_mode,
  input  logic                   dac_req,
  input  cmos_if_pkg::iq_word_t  dac_data,
  output logic                   dac_ack,
  output logic                   tx_frame_p,
  output logic                   tx_frame_n,
  output cmos_if_pkg::half_t     tx_data_p,
  output cmos_if_pkg::half_t     tx_data_n,
  // ensm
  input  logic                   up_enable,
  input  logic                   up_txnrx,
  input  logic                   tdd_mode,
  input  logic                   tdd_enable,
  input  logic                   tdd_txnrx,
  output logic                   enable,
  output logic                   txnrx
);

  import cmos_if_pkg::*;

  bus_mode_t rx_mode;
  bus_mode_t tx_mode;

  assign rx_mode = bus_mode_t'(rx_r1_mode);
  assign tx_mode = bus_mode_t'(tx_r1_mode);

  // captured halves between the two receive stages
  cmos_half_if rx_bus ();

  rx_capture i_rx_capture (
    .l_clk      (l_clk),
    .rst        (rst),
    .rx_frame_p (rx_frame_p),
    .rx_frame_n (rx_frame_n),
    .rx_data_p  (rx_data_p),
    .rx_data_n  (rx_data_n),
    .bus        (rx_bus.capture)
  );

  rx_deframe i_rx_deframe (
    .l_clk      (l_clk),
    .rst        (rst),
    .r1_mode    (rx_mode),
    .bus        (rx_bus.deframe),
    .adc_valid  (adc_valid),
    .adc_status (adc_status),
    .adc_data   (adc_data)
  );

  tx_framer i_tx_framer (
    .l_clk      (l_clk),
    .rst        (rst),
    .r1_mode    (tx_mode),
    .dac_req    (dac_req),
    .dac_data   (dac_data),
    .dac_ack    (dac_ack),
    .tx_frame_p (tx_frame_p),
    .tx_frame_n (tx_frame_n),
    .tx_data_p  (tx_data_p),
    .tx_data_n  (tx_data_n)
  );

  ensm_ctrl #(
    .SYNC_STAGES (SYNC_STAGES)
  ) i_ensm_ctrl (
    .l_clk      (l_clk),
    .rst        (rst),
    .up_enable  (up_enable),
    .up_txnrx   (up_txnrx),
    .tdd_mode   (tdd_mode),
    .tdd_enable (tdd_enable),
    .tdd_txnrx  (tdd_txnrx),
    .enable     (enable),
    .txnrx      (txnrx)
  );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 10
) (
  output logic l_clk,
  output logic rst
);

  initial begin
    l_clk = 1'b0;
    forever #(PERIOD_NS / 2) l_clk = ~l_clk;
  end

  // reset held for a fixed number of rising edges
  initial begin
    rst <= 1'b1;
    repeat (RESET_CYCLES) @(posedge l_clk);
    rst <= 1'b0;
  end

endmodule

// ==== cmos_if_properties.sv ====
`timescale 1ns/1ps

module cmos_if_properties (
  input logic l_clk,
  input logic rst,
  input logic dac_req,
  input logic dac_ack,
  input logic tx_frame_p,
  input logic tx_frame_n,
  input logic adc_valid
);

  int violations = 0;

  // ack may only rise after a request and fall after the request is gone
  ack_rise_order: assert property (@(posedge l_clk) disable iff (rst)
    $rose(dac_ack) |-> $past(dac_req))
    else begin
      violations++;
      $error("dac_ack rose without a pending request");
    end

  ack_fall_order: assert property (@(posedge l_clk) disable iff (rst)
    $fell(dac_ack) |-> !$past(dac_req))
    else begin
      violations++;
      $error("dac_ack fell while the request was still high");
    end

  // (0,1) is never a transmit pattern
  tx_frame_legal: assert property (@(posedge l_clk) disable iff (rst)
    !(!tx_frame_p && tx_frame_n))
    else begin
      violations++;
      $error("transmit frame pair (0,1) seen");
    end

  valid_after_reset: assert property (@(posedge l_clk)
    $fell(rst) |-> !adc_valid)
    else begin
      violations++;
      $error("adc_valid high in the clock after reset");
    end

endmodule

bind cmos_if_top cmos_if_properties props (
  .l_clk      (l_clk),
  .rst        (rst),
  .dac_req    (dac_req),
  .dac_ack    (dac_ack),
  .tx_frame_p (tx_frame_p),
  .tx_frame_n (tx_frame_n),
  .adc_valid  (adc_valid)
);

// ==== cmos_if_tb.sv ====
`timescale 1ns/1ps

module cmos_if_tb;

  import cmos_if_pkg::*;

  localparam int SYNC_STAGES = 2;
  localparam int TIMEOUT     = 50;
  localparam int LOOP_N      = 4;
  localparam int R1S_BASE    = 4;
  localparam int R1S_EXP     = 7;
  localparam int R2S_BASE    = 9;
  localparam int R2S_EXP     = 14;

  logic     l_clk;
  logic     rst;
  logic     rx_r1_mode;
  logic     rx_frame_p;
  logic     rx_frame_n;
  half_t    rx_data_p;
  half_t    rx_data_n;
  logic     adc_valid;
  logic     adc_status;
  iq_word_t adc_data;
  logic     tx_r1_mode;
  logic     dac_req;
  iq_word_t dac_data;
  logic     dac_ack;
  logic     tx_frame_p;
  logic     tx_frame_n;
  half_t    tx_data_p;
  half_t    tx_data_n;
  logic     up_enable;
  logic     up_txnrx;
  logic     tdd_mode;
  logic     tdd_enable;
  logic     tdd_txnrx;
  logic     enable;
  logic     txnrx;

  // direct pin drive, or the transmit bus looped back
  logic     loopback;
  logic     pin_frame_p;
  logic     pin_frame_n;
  half_t    pin_data_p;
  half_t    pin_data_n;

  iq_word_t vecs [0:15];
  int       errors;
  int       tests_run;
  int       tests_failed;
  bit       timed_out;
  int       wait_cycles;

  tb_clk_gen clk_gen (
    .l_clk (l_clk),
    .rst   (rst)
  );

  assign rx_frame_p = loopback ? tx_frame_p : pin_frame_p;
  assign rx_frame_n = loopback ? tx_frame_n : pin_frame_n;
  assign rx_data_p  = loopback ? tx_data_p  : pin_data_p;
  assign rx_data_n  = loopback ? tx_data_n  : pin_data_n;

  cmos_if_top #(
    .SYNC_STAGES (SYNC_STAGES)
  ) DUT (
    .l_clk (l_clk), .rst (rst),
    .rx_r1_mode (rx_r1_mode), .rx_frame_p (rx_frame_p), .rx_frame_n (rx_frame_n),
    .rx_data_p (rx_data_p), .rx_data_n (rx_data_n),
    .adc_valid (adc_valid), .adc_status (adc_status), .adc_data (adc_data),
    .tx_r1_mode (tx_r1_mode), .dac_req (dac_req), .dac_data (dac_data),
    .dac_ack (dac_ack), .tx_frame_p (tx_frame_p), .tx_frame_n (tx_frame_n),
    .tx_data_p (tx_data_p), .tx_data_n (tx_data_n),
    .up_enable (up_enable), .up_txnrx (up_txnrx), .tdd_mode (tdd_mode),
    .tdd_enable (tdd_enable), .tdd_txnrx (tdd_txnrx),
    .enable (enable), .txnrx (txnrx)
  );

  // ************************************************************
  // helpers
  // ************************************************************

  task automatic mismatch(input string name, input iq_word_t exp, input iq_word_t act);
    $display("ERROR %s expected %h actual %h", name, exp, act);
    errors++;
  endtask

  task automatic report(input string name, input int start);
    tests_run++;
    if (errors > start) begin
      tests_failed++;
      $display("FAIL %s", name);
    end else begin
      $display("PASS %s", name);
    end
  endtask

  // frame pair in bits 25:24, p half in 23:12, n half in 11:0
  task automatic drive_pins(input iq_word_t row);
    loopback    <= 1'b0;
    pin_frame_p <= row[25];
    pin_frame_n <= row[24];
    pin_data_p  <= row[23:12];
    pin_data_n  <= row[11:0];
  endtask

  task automatic idle_gap();
    repeat ($urandom_range(6, 2)) @(posedge l_clk);
  endtask

  task automatic wait_ack(input logic level, output bit ok);
    wait_cycles = 0;
    @(negedge l_clk);
    while (dac_ack !== level && wait_cycles < TIMEOUT) begin
      @(negedge l_clk);
      wait_cycles++;
    end
    ok = (dac_ack === level);
    if (!ok) begin
      $display("timeout: dac_ack never went to %0b", level);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_valid(output bit ok);
    wait_cycles = 0;
    @(negedge l_clk);
    while (adc_valid !== 1'b1 && wait_cycles < TIMEOUT) begin
      @(negedge l_clk);
      wait_cycles++;
    end
    ok = (adc_valid === 1'b1);
    if (!ok) begin
      $display("timeout: no received word came back on adc_valid");
      timed_out = 1'b1;
    end
  endtask

  // full four-phase cycle for one word
  task automatic send_word(input iq_word_t word, output bit ok);
    @(posedge l_clk);
    dac_data <= word;
    dac_req  <= 1'b1;
    wait_ack(1'b1, ok);
    if (!ok) return;
    @(posedge l_clk);
    dac_req <= 1'b0;
    wait_ack(1'b0, ok);
  endtask

  // ************************************************************
  // tests
  // ************************************************************

  task automatic send_and_receive(input logic r1, input string name);
    int       start;
    bit       ok;
    iq_word_t exp;
    start = errors;
    @(posedge l_clk);
    loopback   <= 1'b1;
    rx_r1_mode <= r1;
    tx_r1_mode <= r1;
    repeat (4) @(posedge l_clk);
    for (int i = 0; i < LOOP_N; i++) begin
      // r1 carries only the rf1 pair, rf2 reads back as zero
      exp = r1 ? {{(2 * HALF_W){1'b0}}, vecs[i][2*HALF_W-1:0]} : vecs[i];
      send_word(vecs[i], ok);
      if (!ok) return;
      wait_valid(ok);
      if (!ok) return;
      if (adc_data !== exp) mismatch(name, exp, adc_data);
      if (adc_status !== 1'b1) mismatch(name, iq_word_t'(1'b1), iq_word_t'(adc_status));
      idle_gap();
    end
    report(name, start);
  endtask

  // pins driven row by row, each row checked 3 clocks after it is driven
  task automatic decode_shifted(input logic r1, input int base, input int rows,
                                input int exp_base, input string name);
    int       start;
    int       row;
    logic     exp_valid;
    start = errors;
    @(posedge l_clk);
    drive_pins('0);
    rx_r1_mode <= r1;
    repeat (4) @(posedge l_clk);
    for (int c = 0; c < rows + 3; c++) begin
      @(posedge l_clk);
      if (c < rows) drive_pins(vecs[base+c]);
      else drive_pins('0);
      @(negedge l_clk);
      row = c - 3;
      if (row >= 1) begin
        // r2 word completes on every second row
        exp_valid = r1 ? 1'b1 : (row % 2 == 0);
        if (adc_valid !== exp_valid)
          mismatch(name, iq_word_t'(exp_valid), iq_word_t'(adc_valid));
        if (exp_valid && r1 && adc_data !== vecs[exp_base+row-1])
          mismatch(name, vecs[exp_base+row-1], adc_data);
        if (exp_valid && !r1 && adc_data !== vecs[exp_base+row/2-1])
          mismatch(name, vecs[exp_base+row/2-1], adc_data);
        // every window from row 1 on is a good shifted pattern
        if (adc_status !== 1'b1) mismatch(name, iq_word_t'(1'b1), iq_word_t'(adc_status));
      end
    end
    report(name, start);
  endtask

  task automatic reject_bad_frames();
    int start;
    start = errors;
    @(posedge l_clk);
    drive_pins('0);
    rx_r1_mode <= 1'b1;
    repeat (4) @(posedge l_clk);
    for (int c = 0; c < 9; c++) begin
      @(posedge l_clk);
      drive_pins(iq_word_t'({2'b11, 12'($urandom), 12'($urandom)}));
      @(negedge l_clk);
      if (c >= 3 && adc_valid !== 1'b0)
        mismatch("bad_frames", '0, iq_word_t'(adc_valid));
      if (c >= 3 && adc_status !== 1'b0)
        mismatch("bad_frames", '0, iq_word_t'(adc_status));
    end
    report("bad_frames", start);
  endtask

  task automatic hold_request();
    int   start;
    int   rises;
    int   frame_starts;
    logic last_ack;
    bit   ok;
    start = errors;
    @(posedge l_clk);
    loopback   <= 1'b1;
    rx_r1_mode <= 1'b0;
    tx_r1_mode <= 1'b0;
    dac_data   <= vecs[1];
    dac_req    <= 1'b1;
    rises        = 0;
    frame_starts = 0;
    last_ack     = dac_ack;
    // req stays high across the whole two-clock word
    for (int c = 0; c < 8; c++) begin
      @(negedge l_clk);
      if (dac_ack && !last_ack) rises++;
      // an r2 word raises frame_p only on its first bus clock
      if (tx_frame_p) frame_starts++;
      last_ack = dac_ack;
    end
    if (rises != 1) mismatch("backpressure", iq_word_t'(1), iq_word_t'(rises));
    if (frame_starts != 1)
      mismatch("backpressure", iq_word_t'(1), iq_word_t'(frame_starts));
    @(posedge l_clk);
    dac_req <= 1'b0;
    wait_ack(1'b0, ok);
    if (!ok) return;
    send_word(vecs[2], ok);
    if (!ok) return;
    report("backpressure", start);
  endtask

  task automatic select_ensm();
    int start;
    start = errors;
    @(posedge l_clk);
    tdd_mode  <= 1'b0;
    up_enable <= 1'b1;
    up_txnrx  <= 1'b1;
    repeat (SYNC_STAGES) @(posedge l_clk);
    @(negedge l_clk);
    if ({enable, txnrx} !== 2'b00)
      mismatch("ensm_host_early", '0, iq_word_t'({enable, txnrx}));
    @(negedge l_clk);
    if ({enable, txnrx} !== 2'b11)
      mismatch("ensm_host", iq_word_t'(2'b11), iq_word_t'({enable, txnrx}));
    @(posedge l_clk);
    tdd_mode   <= 1'b1;
    tdd_enable <= 1'b0;
    tdd_txnrx  <= 1'b1;
    @(negedge l_clk);
    @(negedge l_clk);
    if ({enable, txnrx} !== 2'b01)
      mismatch("ensm_tdd", iq_word_t'(2'b01), iq_word_t'({enable, txnrx}));
    // swap the tdd pair so that each output follows its own input
    @(posedge l_clk);
    tdd_enable <= 1'b1;
    tdd_txnrx  <= 1'b0;
    @(negedge l_clk);
    @(negedge l_clk);
    if ({enable, txnrx} !== 2'b10)
      mismatch("ensm_tdd", iq_word_t'(2'b10), iq_word_t'({enable, txnrx}));
    report("ensm", start);
  endtask

  initial begin
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    rx_r1_mode  <= 1'b1;
    tx_r1_mode  <= 1'b1;
    dac_req     <= 1'b0;
    dac_data    <= '0;
    up_enable   <= 1'b0;
    up_txnrx    <= 1'b0;
    tdd_mode    <= 1'b0;
    tdd_enable  <= 1'b0;
    tdd_txnrx   <= 1'b0;
    loopback    <= 1'b0;
    pin_frame_p <= 1'b0;
    pin_frame_n <= 1'b0;
    pin_data_p  <= '0;
    pin_data_n  <= '0;
    $readmemh("cmos_if_vectors.txt", vecs);
    void'($urandom(94576));
    wait_cycles = 0;
    while (rst !== 1'b0 && wait_cycles < TIMEOUT) begin
      @(negedge l_clk);
      wait_cycles++;
    end
    if (rst !== 1'b0) begin
      $display("timeout: reset was never released");
      timed_out = 1'b1;
    end
    if (!timed_out) send_and_receive(1'b1, "r1_loopback");
    if (!timed_out) send_and_receive(1'b0, "r2_loopback");
    if (!timed_out) decode_shifted(1'b1, R1S_BASE, 3, R1S_EXP, "r1_shifted");
    if (!timed_out) decode_shifted(1'b0, R2S_BASE, 5, R2S_EXP, "r2_shifted");
    if (!timed_out) reject_bad_frames();
    if (!timed_out) hold_request();
    if (!timed_out) select_ensm();
    repeat (2) @(posedge l_clk);
    $display("tests run %0d, failed %0d, assertion failures %0d",
             tests_run, tests_failed, DUT.props.violations);
    if (errors == 0 && !timed_out && DUT.props.violations == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== cmos_if_vectors.txt ====
// one 48-bit hex value per line, indexes fixed by the testbench
// 0-3 loopback words; pin rows are f_ppp_nnn, f = {frame_p, frame_n}
a5c3f0123456
0f1e2d3c4b5a
fff000fff000
123abc789def
// 4-6 r1 shifted pin rows, all (0,1)
1a01b02
1a03b04
1a05b06
// 7-8 r1 expected words for rows 1 and 2
000000a03b02
000000a05b04
// 9-13 r2 shifted pin rows, (1,0) (0,1) (1,0) (0,1) (1,0)
2c01d02
1c03d04
2c05d06
1c07d08
2c09d0a
// 14-15 r2 expected words for rows 2 and 4
c05d04c03d02
c09d08c07d06

// ==== project.f ====
cmos_if_pkg.sv
cmos_half_if.sv
rx_capture.sv
rx_deframe.sv
tx_framer.sv
ensm_ctrl.sv
cmos_if_top.sv
tb_clk_gen.sv
cmos_if_properties.sv
cmos_if_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module cmos_if_tb \
  -f project.f \
  -o cmos_if_sim

./obj_dir/cmos_if_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -qx "all tests passed" sim.log; then
  exit 0
else
  exit 1
fi
